// File: mem_rd_pkg.sv
// read path shared definitions
`default_nettype none

package mem_rd_pkg;

  // ==========================================================================
  // request data types
  // ==========================================================================

  localparam int d_type_w = 2;               // width of the d_type field

  typedef enum logic [d_type_w-1:0] {
    dt_stream    = 2'd0,                     // shared stream fifo, packed
    dt_stream_pu = 2'd1,                     // per-pu stream fifo, packed
    dt_buffer    = 2'd2                      // buffer-read fifo, memory width
  } d_type_e;

  // ==========================================================================
  // width helpers
  // ==========================================================================

  // free entries held back before a destination reports almost full;
  // covers the pop-to-push pipeline plus the registered flag delay
  localparam int almost_full_margin = 4;

  // pu id width, never below one bit
  function automatic int pu_id_width(input int num_pu);
    return (num_pu > 1) ? $clog2(num_pu) : 1;
  endfunction

  // narrow words per packed word
  function automatic int pack_ratio(input int in_w, input int out_w);
    return out_w / in_w;
  endfunction

endpackage

`default_nettype wire

// File: sync_fifo.sv
// synchronous fifo
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
  parameter int data_w = 32,
  parameter int addr_w = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  logic              pop,
  input  logic [data_w-1:0] data_in,
  output logic [data_w-1:0] data_out,
  output logic              full,
  output logic              empty,
  output logic [addr_w:0]   count
);

  localparam logic [addr_w:0] depth = {1'b1, {addr_w{1'b0}}};

  logic [data_w-1:0] mem [2**addr_w];
  logic [addr_w-1:0] wr_ptr;
  logic [addr_w-1:0] rd_ptr;

  assign full  = (count == depth);
  assign empty = (count == '0);

  // ==========================================================================
  // pointers and occupancy
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= data_in;
  end

  // registered read port, word shows up the cycle after pop
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (pop) begin
      data_out <= mem[rd_ptr];
    end
  end

  // ==========================================================================
  // checks
  // ==========================================================================

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> !full)
    else $error("push into full fifo");

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty)
    else $error("pop from empty fifo");

endmodule

`default_nettype wire

// File: data_packer.sv
// narrow to wide word packer
`timescale 1ns/10ps
`default_nettype none

module data_packer
  import mem_rd_pkg::*;
#(
  parameter int in_w  = 32,
  parameter int out_w = 64
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_push,
  input  logic [in_w-1:0]  in_data,
  output logic             out_push,
  output logic [out_w-1:0] out_data
);

  localparam int ratio = pack_ratio(in_w, out_w);
  localparam int cnt_w = (ratio > 1) ? $clog2(ratio) : 1;

  logic [cnt_w-1:0] word_cnt;                // slot for the next narrow word
  logic [out_w-1:0] partial;                 // words gathered so far
  logic             last_word;

  assign last_word = (word_cnt == cnt_w'(ratio - 1));
  assign out_push  = in_push && last_word;   // same cycle as closing word

  // top slot comes straight from the input
  always_comb begin
    out_data = partial;
    out_data[out_w-in_w +: in_w] = in_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      word_cnt <= '0;
    end else if (in_push) begin
      word_cnt <= last_word ? '0 : word_cnt + 1'b1;
    end
  end

  // first word lands in the low bits
  always_ff @(posedge clk) begin
    if (in_push) partial[word_cnt*in_w +: in_w] <= in_data;
  end

  a_ratio_whole: assert property (@(posedge clk) disable iff (reset)
    (out_w % in_w) == 0)
    else $error("packer output width is not a multiple of input width");

endmodule

`default_nettype wire

// File: read_router.sv
// read beat router
`timescale 1ns/10ps
`default_nettype none

module read_router
  import mem_rd_pkg::*;
#(
  parameter int num_pu     = 2,
  parameter int mem_data_w = 32,
  parameter int tx_size_w  = 8,
  parameter int req_addr_w = 3
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              rd_req,
  input  logic [tx_size_w-1:0]              rd_req_size,
  input  d_type_e                           rd_req_d_type,
  input  logic [pu_id_width(num_pu)-1:0]    rd_req_pu_id,
  output logic                              read_info_full,
  input  logic                              inbuf_empty,
  input  logic [mem_data_w-1:0]             inbuf_data,
  output logic                              inbuf_pop,
  input  logic                              stream_almost_full,
  input  logic [num_pu-1:0]                 stream_pu_almost_full,
  input  logic                              buffer_almost_full,
  output logic                              stream_push,
  output logic [num_pu-1:0]                 stream_pu_push,
  output logic                              buffer_push,
  output logic [mem_data_w-1:0]             beat_data,
  output logic                              beat_last,
  output logic [pu_id_width(num_pu)-1:0]    beat_pu_id
);

  localparam int pu_w  = pu_id_width(num_pu);
  localparam int req_w = pu_w + d_type_w + tx_size_w;

  logic [req_w-1:0]     req_q_data;
  logic                 req_q_empty;
  logic                 req_q_pop;
  logic                 head_valid;          // req_q_data holds the live request
  logic [tx_size_w-1:0] head_size;
  d_type_e              head_type;
  logic [pu_w-1:0]      head_pu;
  logic [tx_size_w-1:0] beat_cnt;
  logic                 dest_ready;
  logic                 retire;

  // ==========================================================================
  // request queue
  // ==========================================================================

  sync_fifo #(
    .data_w (req_w),
    .addr_w (req_addr_w)
  ) i_req_q (
    .clk      (clk),
    .reset    (reset),
    .push     (rd_req),
    .pop      (req_q_pop),
    .data_in  ({rd_req_pu_id, rd_req_d_type, rd_req_size}),
    .data_out (req_q_data),
    .full     (read_info_full),
    .empty    (req_q_empty),
    .count    ()
  );

  assign head_size = req_q_data[tx_size_w-1:0];
  assign head_type = d_type_e'(req_q_data[tx_size_w +: d_type_w]);
  assign head_pu   = req_q_data[tx_size_w+d_type_w +: pu_w];

  assign retire    = inbuf_pop && (beat_cnt == head_size - 1'b1);
  assign req_q_pop = !req_q_empty && (!head_valid || retire);  // refill on retire

  always_ff @(posedge clk) begin
    if (reset) begin
      head_valid <= 1'b0;
      beat_cnt   <= '0;
    end else begin
      if (req_q_pop)   head_valid <= 1'b1;
      else if (retire) head_valid <= 1'b0;
      if (retire)         beat_cnt <= '0;
      else if (inbuf_pop) beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // ==========================================================================
  // routing
  // ==========================================================================

  always_comb begin
    case (head_type)
      dt_stream:    dest_ready = !stream_almost_full;
      dt_stream_pu: dest_ready = !stream_pu_almost_full[head_pu];
      dt_buffer:    dest_ready = !buffer_almost_full;
      default:      dest_ready = 1'b0;
    endcase
  end

  assign inbuf_pop = head_valid && !inbuf_empty && dest_ready;
  assign beat_data = inbuf_data;             // valid with the push strobes

  always_ff @(posedge clk) begin
    if (reset) begin
      stream_push    <= 1'b0;
      stream_pu_push <= '0;
      buffer_push    <= 1'b0;
      beat_last      <= 1'b0;
    end else begin
      stream_push <= inbuf_pop && (head_type == dt_stream);
      buffer_push <= inbuf_pop && (head_type == dt_buffer);
      beat_last   <= retire;
      for (int i = 0; i < num_pu; i++) begin
        stream_pu_push[i] <= inbuf_pop && (head_type == dt_stream_pu) &&
                             (head_pu == pu_w'(i));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (inbuf_pop) beat_pu_id <= head_pu;    // head may change after retire
  end

  // beats never run past the size of the head request
  a_beat_in_range: assert property (@(posedge clk) disable iff (reset)
    inbuf_pop |-> (beat_cnt < head_size))
    else $error("beat popped beyond the size of the head request");

  a_one_push: assert property (@(posedge clk) disable iff (reset)
    $onehot0({stream_push, stream_pu_push, buffer_push}))
    else $error("more than one destination pushed");

endmodule

`default_nettype wire

// File: read_data_top.sv
// read data distribution top
`timescale 1ns/10ps
`default_nettype none

module read_data_top
  import mem_rd_pkg::*;
#(
  parameter int num_pu       = 2,
  parameter int mem_data_w   = 32,
  parameter int pu_data_w    = 64,
  parameter int tx_size_w    = 8,
  parameter int inbuf_addr_w = 4,
  parameter int dest_addr_w  = 4,
  parameter int req_addr_w   = 3
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           rd_req,
  input  logic [tx_size_w-1:0]           rd_req_size,
  input  d_type_e                        rd_req_d_type,
  input  logic [pu_id_width(num_pu)-1:0] rd_req_pu_id,
  output logic                           read_info_full,
  input  logic                           resp_valid,
  input  logic [mem_data_w-1:0]          resp_data,
  output logic                           inbuf_full,
  input  logic                           stream_fifo_pop,
  output logic                           stream_fifo_empty,
  output logic [pu_data_w-1:0]           stream_fifo_data,
  input  logic [num_pu-1:0]              stream_pu_pop,
  output logic [num_pu-1:0]              stream_pu_empty,
  output logic [num_pu*pu_data_w-1:0]    stream_pu_data,
  input  logic                           buffer_read_pop,
  output logic                           buffer_read_empty,
  output logic [mem_data_w-1:0]          buffer_read_data,
  output logic                           buffer_read_last,
  output logic [pu_id_width(num_pu)-1:0] buffer_pu_id
);

  localparam int pu_w  = pu_id_width(num_pu);
  localparam int buf_w = pu_w + 1 + mem_data_w;
  localparam logic [dest_addr_w:0] af_level =
    (dest_addr_w+1)'((1 << dest_addr_w) - almost_full_margin);

  logic                  inbuf_empty, inbuf_pop;
  logic [mem_data_w-1:0] inbuf_data;
  logic                  stream_push, buffer_push, beat_last;
  logic [num_pu-1:0]     stream_pu_push;
  logic [mem_data_w-1:0] beat_data;
  logic [pu_w-1:0]       beat_pu_id;
  logic                  stream_almost_full, buffer_almost_full;
  logic [num_pu-1:0]     stream_pu_almost_full;
  logic                  stream_pk_push;
  logic [pu_data_w-1:0]  stream_pk_data;
  logic [dest_addr_w:0]  stream_count, buffer_count;
  logic [buf_w-1:0]      buffer_q_data;

  // ==========================================================================
  // input buffer and router
  // ==========================================================================

  sync_fifo #(.data_w(mem_data_w), .addr_w(inbuf_addr_w)) i_inbuf (
    .clk(clk), .reset(reset), .push(resp_valid), .pop(inbuf_pop),
    .data_in(resp_data), .data_out(inbuf_data), .full(inbuf_full),
    .empty(inbuf_empty), .count()
  );

  read_router #(
    .num_pu(num_pu), .mem_data_w(mem_data_w),
    .tx_size_w(tx_size_w), .req_addr_w(req_addr_w)
  ) i_read_router (
    .clk(clk), .reset(reset), .rd_req(rd_req), .rd_req_size(rd_req_size),
    .rd_req_d_type(rd_req_d_type), .rd_req_pu_id(rd_req_pu_id),
    .read_info_full(read_info_full), .inbuf_empty(inbuf_empty),
    .inbuf_data(inbuf_data), .inbuf_pop(inbuf_pop),
    .stream_almost_full(stream_almost_full),
    .stream_pu_almost_full(stream_pu_almost_full),
    .buffer_almost_full(buffer_almost_full), .stream_push(stream_push),
    .stream_pu_push(stream_pu_push), .buffer_push(buffer_push),
    .beat_data(beat_data), .beat_last(beat_last), .beat_pu_id(beat_pu_id)
  );

  // ==========================================================================
  // shared stream
  // ==========================================================================

  data_packer #(.in_w(mem_data_w), .out_w(pu_data_w)) i_stream_packer (
    .clk(clk), .reset(reset), .in_push(stream_push), .in_data(beat_data),
    .out_push(stream_pk_push), .out_data(stream_pk_data)
  );

  sync_fifo #(.data_w(pu_data_w), .addr_w(dest_addr_w)) i_stream_fifo (
    .clk(clk), .reset(reset), .push(stream_pk_push), .pop(stream_fifo_pop),
    .data_in(stream_pk_data), .data_out(stream_fifo_data), .full(),
    .empty(stream_fifo_empty), .count(stream_count)
  );

  // ==========================================================================
  // per-pu streams
  // ==========================================================================

  for (genvar i = 0; i < num_pu; i++) begin : g_stream_pu
    logic                 pk_push;
    logic [pu_data_w-1:0] pk_data;
    logic [dest_addr_w:0] pu_count;

    data_packer #(.in_w(mem_data_w), .out_w(pu_data_w)) i_packer (
      .clk(clk), .reset(reset), .in_push(stream_pu_push[i]), .in_data(beat_data),
      .out_push(pk_push), .out_data(pk_data)
    );

    sync_fifo #(.data_w(pu_data_w), .addr_w(dest_addr_w)) i_fifo (
      .clk(clk), .reset(reset), .push(pk_push), .pop(stream_pu_pop[i]),
      .data_in(pk_data), .data_out(stream_pu_data[i*pu_data_w +: pu_data_w]),
      .full(), .empty(stream_pu_empty[i]), .count(pu_count)
    );

    always_ff @(posedge clk) begin
      if (reset) stream_pu_almost_full[i] <= 1'b0;
      else       stream_pu_almost_full[i] <= (pu_count >= af_level);
    end
  end

  // ==========================================================================
  // buffer read path
  // ==========================================================================

  sync_fifo #(.data_w(buf_w), .addr_w(dest_addr_w)) i_buffer_fifo (
    .clk(clk), .reset(reset), .push(buffer_push), .pop(buffer_read_pop),
    .data_in({beat_pu_id, beat_last, beat_data}), .data_out(buffer_q_data),
    .full(), .empty(buffer_read_empty), .count(buffer_count)
  );

  assign buffer_read_data = buffer_q_data[mem_data_w-1:0];
  assign buffer_read_last = buffer_q_data[mem_data_w];
  assign buffer_pu_id     = buffer_q_data[mem_data_w+1 +: pu_w];

  // one cycle late, margin absorbs it
  always_ff @(posedge clk) begin
    if (reset) begin
      stream_almost_full <= 1'b0;
      buffer_almost_full <= 1'b0;
    end else begin
      stream_almost_full <= (stream_count >= af_level);
      buffer_almost_full <= (buffer_count >= af_level);
    end
  end

endmodule

`default_nettype wire

// File: tb_read_data_top.sv
// read data path testbench
`timescale 1ns/10ps
`default_nettype none

module tb_read_data_top
  import mem_rd_pkg::*;
();

  localparam int num_pu       = 2;
  localparam int mem_data_w   = 32;
  localparam int pu_data_w    = 64;
  localparam int tx_size_w    = 8;
  localparam int inbuf_addr_w = 3;                 // small buffers so a held
  localparam int dest_addr_w  = 3;                 // stream backs up to the input
  localparam int pu_w         = pu_id_width(num_pu);
  localparam int clk_period   = 20;

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        rd_req;
  logic [tx_size_w-1:0]        rd_req_size;
  d_type_e                     rd_req_d_type;
  logic [pu_w-1:0]             rd_req_pu_id;
  logic                        read_info_full;
  logic                        resp_valid;
  logic [mem_data_w-1:0]       resp_data;
  logic                        inbuf_full;
  logic                        stream_fifo_pop;
  logic                        stream_fifo_empty;
  logic [pu_data_w-1:0]        stream_fifo_data;
  logic [num_pu-1:0]           stream_pu_pop;
  logic [num_pu-1:0]           stream_pu_empty;
  logic [num_pu*pu_data_w-1:0] stream_pu_data;
  logic                        buffer_read_pop;
  logic                        buffer_read_empty;
  logic [mem_data_w-1:0]       buffer_read_data;
  logic                        buffer_read_last;
  logic [pu_w-1:0]             buffer_pu_id;

  // expected model state
  int                          req_size [$];
  d_type_e                     req_type [$];
  int                          req_pu [$];
  int                          beat_idx = 0;       // beat within head request
  logic [pu_data_w-1:0]        stream_exp [$];
  logic [pu_data_w-1:0]        pu_exp [num_pu][$];
  logic [pu_w+mem_data_w:0]    buffer_exp [$];     // {pu, last, data}
  logic [mem_data_w-1:0]       stream_low;
  bit                          stream_odd = 1'b0;
  logic [mem_data_w-1:0]       pu_low [num_pu];
  bit                          pu_odd [num_pu];

  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     hold_cycles = 0;                         // shared stream pops withheld
  int     line_total = 0;
  bit     hold_armed = 1'b0;                       // current test holds the stream
  bit     saw_inbuf_full = 1'b0;
  integer seed = 32'hb3490ddc;

  always #(clk_period/2) clk = ~clk;

  read_data_top #(
    .num_pu(num_pu), .mem_data_w(mem_data_w), .pu_data_w(pu_data_w),
    .tx_size_w(tx_size_w), .inbuf_addr_w(inbuf_addr_w), .dest_addr_w(dest_addr_w),
    .req_addr_w(3)
  ) i_read_data_top (
    .clk(clk), .reset(reset), .rd_req(rd_req), .rd_req_size(rd_req_size),
    .rd_req_d_type(rd_req_d_type), .rd_req_pu_id(rd_req_pu_id),
    .read_info_full(read_info_full), .resp_valid(resp_valid), .resp_data(resp_data),
    .inbuf_full(inbuf_full), .stream_fifo_pop(stream_fifo_pop),
    .stream_fifo_empty(stream_fifo_empty), .stream_fifo_data(stream_fifo_data),
    .stream_pu_pop(stream_pu_pop), .stream_pu_empty(stream_pu_empty),
    .stream_pu_data(stream_pu_data), .buffer_read_pop(buffer_read_pop),
    .buffer_read_empty(buffer_read_empty), .buffer_read_data(buffer_read_data),
    .buffer_read_last(buffer_read_last), .buffer_pu_id(buffer_pu_id)
  );

  // ==========================================================================
  // checking helpers
  // ==========================================================================

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_unexpected(input string where);
    errors++;
    $display("a word was popped from %s although none was expected", where);
  endtask

  function automatic bit all_drained();
    bit done;
    done = (stream_exp.size() == 0) && (buffer_exp.size() == 0) &&
           stream_fifo_empty && buffer_read_empty && (&stream_pu_empty);
    for (int i = 0; i < num_pu; i++) begin
      if (pu_exp[i].size() != 0) done = 1'b0;
    end
    return done;
  endfunction

  // route one beat through the model, pairs packed low half first
  task automatic expect_beat(input logic [mem_data_w-1:0] data);
    int p;
    if (req_size.size() == 0) begin
      errors++;
      $display("stimulus beat %h arrives with no open request", data);
    end else begin
      p = req_pu[0];
      case (req_type[0])
        dt_stream: begin
          if (stream_odd) stream_exp.push_back({data, stream_low});
          else            stream_low = data;
          stream_odd = !stream_odd;
        end
        dt_stream_pu: begin
          if (pu_odd[p]) pu_exp[p].push_back({data, pu_low[p]});
          else           pu_low[p] = data;
          pu_odd[p] = !pu_odd[p];
        end
        default: buffer_exp.push_back({pu_w'(p), beat_idx == req_size[0] - 1, data});
      endcase
      beat_idx++;
      if (beat_idx == req_size[0]) begin     // request retires on its last beat
        beat_idx = 0;
        void'(req_size.pop_front());
        void'(req_type.pop_front());
        void'(req_pu.pop_front());
      end
    end
  endtask

  // ==========================================================================
  // drivers
  // ==========================================================================

  task automatic send_request(input int size, input int dtype, input int pu);
    while (read_info_full) begin
      @(posedge clk);
      #1;
    end
    rd_req        = 1'b1;
    rd_req_size   = tx_size_w'(size);
    rd_req_d_type = d_type_e'(dtype);
    rd_req_pu_id  = pu_w'(pu);
    req_size.push_back(size);
    req_type.push_back(d_type_e'(dtype));
    req_pu.push_back(pu);
    @(posedge clk);
    #1;
    rd_req = 1'b0;
  endtask

  task automatic send_beat(input logic [mem_data_w-1:0] data);
    while (inbuf_full) begin                 // hold off while buffer is full
      saw_inbuf_full = 1'b1;
      @(posedge clk);
      #1;
    end
    resp_valid = 1'b1;
    resp_data  = data;
    expect_beat(data);
    @(posedge clk);
    #1;
    resp_valid = 1'b0;
  endtask

  task automatic drain(input int max_cycles);
    int n;
    n = 0;
    while (!all_drained() && n < max_cycles) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!all_drained()) begin
      errors++;
      $display("outputs were still pending after %0d drain cycles", max_cycles);
    end
  endtask

  // consumers, read data checked the cycle after each pop
  always @(posedge clk) begin : consume
    logic [pu_w+mem_data_w:0] b;
    #1;
    if (stream_fifo_pop) begin
      if (stream_exp.size() == 0) report_unexpected("the shared stream");
      else check_value("stream_fifo_data", stream_fifo_data, stream_exp.pop_front());
    end
    for (int i = 0; i < num_pu; i++) begin
      if (stream_pu_pop[i]) begin
        if (pu_exp[i].size() == 0) report_unexpected($sformatf("PU lane %0d", i));
        else check_value($sformatf("stream_pu_data[%0d]", i),
                         stream_pu_data[i*pu_data_w +: pu_data_w], pu_exp[i].pop_front());
      end
    end
    if (buffer_read_pop) begin
      if (buffer_exp.size() == 0) begin
        report_unexpected("the buffer read FIFO");
      end else begin
        b = buffer_exp.pop_front();
        check_value("buffer_read_data", buffer_read_data, b[mem_data_w-1:0]);
        check_value("buffer_read_last", buffer_read_last, b[mem_data_w]);
        check_value("buffer_pu_id", buffer_pu_id, b[mem_data_w+1 +: pu_w]);
      end
    end
    if (hold_cycles > 0) hold_cycles--;
    stream_fifo_pop = !reset && !stream_fifo_empty && (hold_cycles == 0);
    stream_pu_pop   = ~stream_pu_empty & {num_pu{!reset}};
    buffer_read_pop = !reset && !buffer_read_empty;
  end

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin : main
    int                    fd;
    int                    n;
    int                    a;
    int                    b;
    int                    c;
    int                    test_errors;
    logic [mem_data_w-1:0] d;
    string                 line;
    byte                   cmd;
    reset           = 1'b1;
    rd_req          = 1'b0;
    rd_req_size     = '0;
    rd_req_d_type   = dt_stream;
    rd_req_pu_id    = '0;
    resp_valid      = 1'b0;
    resp_data       = '0;
    stream_fifo_pop = 1'b0;
    stream_pu_pop   = '0;
    buffer_read_pop = 1'b0;
    for (int i = 0; i < num_pu; i++) pu_odd[i] = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    test_errors = errors;
    check_value("stream_fifo_empty", stream_fifo_empty, 1);
    check_value("stream_pu_empty", stream_pu_empty, {num_pu{1'b1}});
    check_value("buffer_read_empty", buffer_read_empty, 1);
    check_value("read_info_full", read_info_full, 0);
    check_value("inbuf_full", inbuf_full, 0);
    check_value("buffer_read_last", buffer_read_last, 0);
    $display("test 1 finished: %0d errors", errors - test_errors);
    tests_run++;

    fd = $fopen("read_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open read_stimulus.txt");
    end else begin
      n = 0;
      while ($fgets(line, fd) > 0) n++;
      $fclose(fd);
      line_total = n;                          // arms the watchdog
      fd = $fopen("read_stimulus.txt", "r");
      test_errors = errors;
      while ($fgets(line, fd) > 0) begin
        cmd = line.getc(0);
        if (cmd == "r") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%d %d %d", a, b, c);
          send_request(a, b, c);
        end else if (cmd == "b") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%h %d", d, a);
          for (int i = 0; i < a; i++) send_beat(d + mem_data_w'(i));
        end else if (cmd == "h") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%d", a);
          hold_cycles = a + ({$random(seed)} % (a + 1));
          hold_armed = 1'b1;
          saw_inbuf_full = 1'b0;
        end else if (cmd == "d") begin
          n = $sscanf(line.substr(1, line.len() - 1), "%d %d", a, b);
          drain(a);
          if (hold_armed && !saw_inbuf_full) begin
            errors++;
            $display("the input buffer never filled while stream pops were held");
          end
          hold_armed = 1'b0;
          $display("test %0d finished: %0d errors", b, errors - test_errors);
          tests_run++;
          test_errors = errors;
        end
      end
      $fclose(fd);
    end

    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // forty cycles per stimulus line
  initial begin : watchdog
    wait (line_total > 0);
    #(line_total * 40 * clk_period);
    $display("timeout: the run did not finish within %0d cycles", line_total * 40);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: read_stimulus.txt
# r <size> <type 0 stream, 1 stream_pu, 2 buffer> <pu>   b <hex data> <beat count>
# h <base stream hold cycles>   d <max drain cycles> <test number>
r 4 0 0
b 10000000 4
d 100 2
r 2 1 0
r 4 1 1
r 2 1 0
b 20000000 8
d 100 3
r 3 2 1
b 30000000 3
d 100 4
h 30
r 24 0 0
b 40000000 24
d 300 5

// File: all.f
mem_rd_pkg.sv
sync_fifo.sv
data_packer.sv
read_router.sv
read_data_top.sv
tb_read_data_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_read_data_top \
  -f all.f -o sim_read_data > build.log 2>&1 \
  && ./obj_dir/sim_read_data > sim.log 2>&1 \
  || { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
